// File: hw/sm83_alu_pkg.sv
/* SM83 ALU shared definitions
 * data width, flag byte layout, operation queue sizing and the ALU opcode set
 */
package sm83_alu_pkg;

	localparam int WORD_SIZE   = 8;             // accumulator and operand width
	localparam int NIBBLE_SIZE = WORD_SIZE / 2; // the adder works one nibble at a time

	// flag positions in the F byte, low nibble always reads zero
	localparam int FLAG_Z = 7;
	localparam int FLAG_N = 6;
	localparam int FLAG_H = 5;
	localparam int FLAG_C = 4;

	// queue depth is also the number of credits the issuer starts with
	localparam int QUEUE_DEPTH = 4;                      // must stay a power of two
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);     // pointers wrap on their own
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1); // occupancy needs to reach full

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,  // a + b
		OP_ADC  = 4'd1,  // a + b + C
		OP_SUB  = 4'd2,  // a - b
		OP_SBC  = 4'd3,  // a - b - C
		OP_AND  = 4'd4,
		OP_XOR  = 4'd5,
		OP_OR   = 4'd6,
		OP_CP   = 4'd7,  // compare, flags of a - b with a kept
		OP_RL   = 4'd8,  // rotate left through carry
		OP_RR   = 4'd9,  // rotate right through carry
		OP_DAA  = 4'd10, // decimal adjust of a
		OP_SCF  = 4'd11, // set carry
		OP_CCF  = 4'd12, // complement carry
		OP_POPF = 4'd13  // load the flags from b like a pop of AF
	} alu_op_e;

endpackage

// File: hw/sm83_op_queue.sv
/* SM83 ALU operation queue
 * circular buffer for issued operations, pops its head every cycle it holds one
 * and hands back one credit per pop
 */
`timescale 1ns/100ps

module sm83_op_queue (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 issue_valid,
	input  sm83_alu_pkg::alu_op_e                issue_op,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0]   issue_a,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0]   issue_b,
	output logic                                 head_valid,
	output sm83_alu_pkg::alu_op_e                head_op,
	output logic [sm83_alu_pkg::WORD_SIZE-1:0]   head_a,
	output logic [sm83_alu_pkg::WORD_SIZE-1:0]   head_b,
	output logic                                 credit_return
);

	sm83_alu_pkg::alu_op_e              op_mem [sm83_alu_pkg::QUEUE_DEPTH];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] a_mem  [sm83_alu_pkg::QUEUE_DEPTH];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] b_mem  [sm83_alu_pkg::QUEUE_DEPTH];

	logic [sm83_alu_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [sm83_alu_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [sm83_alu_pkg::QUEUE_CNT_W-1:0] count; // entries currently held
	logic                                 pop;

	// the ALU never stalls, so anything at the head leaves on the next edge
	assign head_valid = (count != '0);
	assign pop        = head_valid;

	assign head_op = op_mem[rd_ptr];
	assign head_a  = a_mem[rd_ptr];
	assign head_b  = b_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (issue_valid) begin // a credit guarantees a free slot
			op_mem[wr_ptr] <= issue_op;
			a_mem[wr_ptr]  <= issue_a;
			b_mem[wr_ptr]  <= issue_b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (issue_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + sm83_alu_pkg::QUEUE_CNT_W'(issue_valid)
			               - sm83_alu_pkg::QUEUE_CNT_W'(pop);
			credit_return <= pop; // one cycle after the pop edge
		end
	end

endmodule

// File: hw/sm83_alu_control.sv
/* SM83 ALU control
 * turns the head opcode into flag update strobes and sources, routes the
 * datapath flags to the flag register and works out the DAA correction
 */
`timescale 1ns/100ps

module sm83_alu_control (
	input  logic                               head_valid,
	input  sm83_alu_pkg::alu_op_e              head_op,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0] head_a,
	input  logic                               half_carry,
	input  logic                               daa_carry,
	input  logic                               neg,
	input  logic                               carry,
	input  logic                               carry_out,      // datapath flags
	input  logic                               half_carry_out,
	input  logic                               zero_out,
	input  logic                               shift_out,
	output sm83_alu_pkg::alu_op_e              core_op,
	output logic [sm83_alu_pkg::WORD_SIZE-1:0] daa_adjust,
	output logic                               flags_bus,
	output logic                               flags_alu,
	output logic                               zero_we,
	output logic                               zero_clr,
	output logic                               half_carry_we,
	output logic                               half_carry_set,
	output logic                               half_carry_cpl,
	output logic                               daa_carry_we,
	output logic                               neg_we,
	output logic                               neg_set,
	output logic                               neg_clr,
	output logic                               carry_we,
	output logic                               sec_carry_we,
	output logic                               sec_carry_sh,
	output logic                               sec_carry_daa,
	output logic                               sec_carry_sel,
	output logic                               carry_set,
	output logic                               carry_cpl,
	output logic                               carry_in,       // to the flag register
	output logic                               zero_in,
	output logic                               shift_out_in,
	output logic                               daa_carry_in,
	output logic                               sign_in
);

	logic arith;  // ops whose H comes out of the adder
	logic daa_h;  // H as DAA sees it
	logic daa_lo; // low digit needs a 6
	logic daa_hi; // high digit needs a 6

	assign core_op = head_op;
	assign arith   = head_op inside {sm83_alu_pkg::OP_ADD, sm83_alu_pkg::OP_ADC,
	                                 sm83_alu_pkg::OP_SUB, sm83_alu_pkg::OP_SBC,
	                                 sm83_alu_pkg::OP_CP};

	// daa_carry keeps the raw nibble carry, half_carry adds the forced H of AND
	assign daa_h  = half_carry || daa_carry;
	// after a subtraction only the recorded borrows count
	assign daa_lo = neg ? daa_h : (daa_h || head_a[3:0] > 4'd9);
	assign daa_hi = neg ? carry : (carry || head_a > 8'h99);
	assign daa_adjust   = (daa_hi ? 8'h60 : 8'h00) | (daa_lo ? 8'h06 : 8'h00);
	assign daa_carry_in = daa_hi; // C stays set once the high digit was corrected

	// H only comes from the adder, everything else writes a zero into it
	assign carry_in     = arith ? half_carry_out : 1'b0;
	assign shift_out_in = (head_op inside {sm83_alu_pkg::OP_RL, sm83_alu_pkg::OP_RR})
	                      ? shift_out : carry_out;
	assign zero_in      = zero_out;
	assign sign_in      = head_op inside {sm83_alu_pkg::OP_SUB, sm83_alu_pkg::OP_SBC};

	assign half_carry_cpl = 1'b0; // no SM83 op complements H

	always_comb begin
		flags_bus      = 1'b0;
		flags_alu      = 1'b0;
		zero_we        = 1'b0;
		zero_clr       = 1'b0;
		half_carry_we  = 1'b0;
		half_carry_set = 1'b0;
		daa_carry_we   = 1'b0;
		neg_we         = 1'b0;
		neg_set        = 1'b0;
		neg_clr        = 1'b0;
		carry_we       = 1'b0;
		sec_carry_we   = 1'b0;
		sec_carry_sh   = 1'b0;
		sec_carry_daa  = 1'b0;
		sec_carry_sel  = 1'b0;
		carry_set      = 1'b0;
		carry_cpl      = 1'b0;
		if (head_valid) begin
			// every op writes H and C, POPF into the primary carry and the rest into the secondary
			flags_bus     = (head_op == sm83_alu_pkg::OP_POPF);
			flags_alu     = !flags_bus;
			half_carry_we = 1'b1;
			daa_carry_we  = 1'b1;
			carry_we      = 1'b1;
			sec_carry_we  = flags_alu;
			sec_carry_sel = flags_alu;
			sec_carry_sh  = flags_alu; // shift_out_in carries the bit 7 carry as well
			unique case (head_op)
				sm83_alu_pkg::OP_ADD, sm83_alu_pkg::OP_ADC,
				sm83_alu_pkg::OP_SUB, sm83_alu_pkg::OP_SBC: begin
					zero_we = 1'b1;
					neg_we  = 1'b1; // N follows sign_in
				end
				sm83_alu_pkg::OP_CP: begin
					zero_we = 1'b1;
					neg_we  = 1'b1;
					neg_set = 1'b1;
				end
				sm83_alu_pkg::OP_AND, sm83_alu_pkg::OP_XOR, sm83_alu_pkg::OP_OR: begin
					zero_we        = 1'b1;
					neg_we         = 1'b1;
					neg_clr        = 1'b1;
					half_carry_set = (head_op == sm83_alu_pkg::OP_AND);
				end
				sm83_alu_pkg::OP_RL, sm83_alu_pkg::OP_RR: begin
					zero_we  = 1'b1;
					zero_clr = 1'b1; // accumulator rotates always leave Z clear
					neg_we   = 1'b1;
					neg_clr  = 1'b1;
				end
				sm83_alu_pkg::OP_DAA: begin
					zero_we       = 1'b1; // N is left alone
					sec_carry_sh  = 1'b0;
					sec_carry_daa = 1'b1;
				end
				sm83_alu_pkg::OP_SCF: begin
					neg_we    = 1'b1;
					neg_clr   = 1'b1;
					carry_set = 1'b1;
				end
				sm83_alu_pkg::OP_CCF: begin
					neg_we    = 1'b1;
					neg_clr   = 1'b1;
					carry_cpl = 1'b1; // the core passes the old C through
				end
				sm83_alu_pkg::OP_POPF: begin
					zero_we = 1'b1;
					neg_we  = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hw/sm83_alu_core.sv
/* SM83 ALU datapath
 * 8-bit add, subtract, logic and rotate built from two nibble adds, with the
 * half carry of the low nibble feeding the high one
 */
`timescale 1ns/100ps

module sm83_alu_core (
	input  sm83_alu_pkg::alu_op_e              core_op,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0] a,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0] b,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0] daa_adjust,
	input  logic                               neg,   // direction of the DAA correction
	input  logic                               carry,
	output logic [sm83_alu_pkg::WORD_SIZE-1:0] result,
	output logic                               carry_out,
	output logic                               half_carry_out,
	output logic                               zero_out,
	output logic                               shift_out
);

	logic [sm83_alu_pkg::WORD_SIZE-1:0]   y;      // second adder operand
	logic                                 sub;    // adder runs a + ~y + cin
	logic                                 cin;
	logic [sm83_alu_pkg::NIBBLE_SIZE:0]   lo_sum; // top bit is the half carry
	logic [sm83_alu_pkg::NIBBLE_SIZE:0]   hi_sum;
	logic [sm83_alu_pkg::WORD_SIZE-1:0]   val;

	always_comb begin
		sub = (core_op inside {sm83_alu_pkg::OP_SUB, sm83_alu_pkg::OP_SBC, sm83_alu_pkg::OP_CP})
		      || (core_op == sm83_alu_pkg::OP_DAA && neg);
		y   = (core_op == sm83_alu_pkg::OP_DAA) ? daa_adjust : b;
		if (sub)
			y = ~y;
		if (core_op == sm83_alu_pkg::OP_ADC)
			cin = carry;
		else if (core_op == sm83_alu_pkg::OP_SBC)
			cin = !carry; // a - b - C is a + ~b + !C
		else
			cin = sub;
	end

	assign lo_sum = {1'b0, a[3:0]} + {1'b0, y[3:0]} + {4'b0, cin};
	assign hi_sum = {1'b0, a[7:4]} + {1'b0, y[7:4]} + {4'b0, lo_sum[4]};

	always_comb begin
		val            = {hi_sum[3:0], lo_sum[3:0]};
		carry_out      = hi_sum[4] ^ sub; // a missing carry is a borrow
		half_carry_out = lo_sum[4] ^ sub;
		shift_out      = 1'b0;
		unique case (core_op)
			sm83_alu_pkg::OP_AND: begin
				val            = a & b;
				carry_out      = 1'b0;
				half_carry_out = 1'b0;
			end
			sm83_alu_pkg::OP_XOR: begin
				val            = a ^ b;
				carry_out      = 1'b0;
				half_carry_out = 1'b0;
			end
			sm83_alu_pkg::OP_OR: begin
				val            = a | b;
				carry_out      = 1'b0;
				half_carry_out = 1'b0;
			end
			sm83_alu_pkg::OP_RL: begin
				val            = {a[6:0], carry}; // old C fills bit 0
				shift_out      = a[7];
				half_carry_out = 1'b0;
			end
			sm83_alu_pkg::OP_RR: begin
				val            = {carry, a[7:1]};
				shift_out      = a[0];
				half_carry_out = 1'b0;
			end
			sm83_alu_pkg::OP_SCF, sm83_alu_pkg::OP_CCF, sm83_alu_pkg::OP_POPF: begin
				val            = a;
				carry_out      = carry; // CCF inverts this in the flag register
				half_carry_out = 1'b0;
			end
			default: ; // add, subtract, compare and DAA keep the adder output
		endcase
	end

	// compare reports Z of the difference but hands a back untouched
	assign zero_out = (val == '0);
	assign result   = (core_op == sm83_alu_pkg::OP_CP) ? a : val;

endmodule

// File: hw/sm83_alu_flags.sv
/* SM83 flag register
 * Z, N, H and the primary and secondary carry with the saved DAA half carry,
 * loaded from the ALU or from the data bus, and the F byte for the bus
 */
`timescale 1ns/100ps

module sm83_alu_flags (
	input  logic                               clk,
	input  logic                               reset,
	output logic [sm83_alu_pkg::WORD_SIZE-1:0] dout,   // F byte out to the data bus
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0] din,    // F byte in from the data bus
	input  logic                               flags_bus,
	input  logic                               flags_alu,
	input  logic                               zero_we,
	input  logic                               zero_clr,
	input  logic                               half_carry_we,
	input  logic                               half_carry_set,
	input  logic                               half_carry_cpl,
	input  logic                               daa_carry_we,
	input  logic                               neg_we,
	input  logic                               neg_set,
	input  logic                               neg_clr,
	input  logic                               carry_we,
	input  logic                               sec_carry_we,
	input  logic                               sec_carry_sh,
	input  logic                               sec_carry_daa,
	input  logic                               sec_carry_sel,
	input  logic                               carry_set,
	input  logic                               carry_cpl,
	input  logic                               zero_in,
	input  logic                               carry_in,
	input  logic                               shift_out_in,
	input  logic                               daa_carry_in,
	input  logic                               sign_in,
	output logic                               zero,
	output logic                               half_carry,
	output logic                               daa_carry,
	output logic                               neg,
	output logic                               carry,
	output logic                               pri_carry
);

	logic hc_reg;
	logic sec_c_reg;
	logic carry_sel; // set while C lives in the secondary register
	logic pri_c_we;
	logic zero_src;  // bus or ALU source, whichever strobe is up
	logic neg_src;
	logic h_src;
	logic c_src;
	logic sec_src;

	assign zero_src = (flags_bus && din[sm83_alu_pkg::FLAG_Z]) || (flags_alu && zero_in);
	assign neg_src  = (flags_bus && din[sm83_alu_pkg::FLAG_N]) || (flags_alu && sign_in);
	assign h_src    = (flags_bus && din[sm83_alu_pkg::FLAG_H]) || (flags_alu && carry_in);
	assign c_src    = (flags_bus && din[sm83_alu_pkg::FLAG_C]) || (flags_alu && carry_in);

	always_comb begin
		unique case ({sec_carry_daa, sec_carry_sh})
			2'b00:   sec_src = carry_in;
			2'b01:   sec_src = shift_out_in;
			2'b10:   sec_src = daa_carry_in;
			default: sec_src = 1'b0;
		endcase
	end

	// a secondary write holds the primary carry where it is
	assign pri_c_we = carry_we && !sec_carry_we;

	always_ff @(posedge clk) begin
		if (reset) begin
			zero      <= 1'b0;
			neg       <= 1'b0;
			hc_reg    <= 1'b0;
			daa_carry <= 1'b0;
			pri_carry <= 1'b0;
			sec_c_reg <= 1'b0;
			carry_sel <= 1'b0;
		end else begin
			if (zero_we)
				zero <= zero_src && !zero_clr;
			if (neg_we)
				neg <= neg_set || (neg_src && !neg_clr);
			if (half_carry_we)
				hc_reg <= (h_src || half_carry_set) ^ half_carry_cpl;
			if (daa_carry_we)
				daa_carry <= h_src; // raw nibble carry, no set or complement
			if (pri_c_we)
				pri_carry <= (c_src || carry_set) ^ carry_cpl;
			if (sec_carry_we)
				sec_c_reg <= (sec_src || carry_set) ^ carry_cpl;
			if (carry_we)
				carry_sel <= sec_carry_sel; // remember which register now holds C
		end
	end

	assign half_carry = hc_reg;
	assign carry      = carry_sel ? sec_c_reg : pri_carry;

	assign dout[sm83_alu_pkg::FLAG_Z]   = zero;
	assign dout[sm83_alu_pkg::FLAG_N]   = neg;
	assign dout[sm83_alu_pkg::FLAG_H]   = half_carry;
	assign dout[sm83_alu_pkg::FLAG_C]   = carry;
	assign dout[sm83_alu_pkg::FLAG_C-1:0] = '0;

endmodule

// File: hw/sm83_alu_unit.sv
/* SM83 ALU unit
 * credit fed operation queue in front of control, datapath and flag register,
 * returns one registered result with its F byte per operation
 */
`timescale 1ns/100ps

module sm83_alu_unit (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               issue_valid,
	input  sm83_alu_pkg::alu_op_e              issue_op,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0] issue_a,
	input  logic [sm83_alu_pkg::WORD_SIZE-1:0] issue_b,
	output logic                               credit_return,
	output logic                               result_valid,
	output logic [sm83_alu_pkg::WORD_SIZE-1:0] result,
	output logic [sm83_alu_pkg::WORD_SIZE-1:0] flags
);

	logic                               head_valid;
	sm83_alu_pkg::alu_op_e              head_op;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] head_a;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] head_b;
	sm83_alu_pkg::alu_op_e              core_op;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] daa_adjust;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] core_result;
	logic carry_out, half_carry_out, zero_out, shift_out;
	logic flags_bus, flags_alu, zero_we, zero_clr;
	logic half_carry_we, half_carry_set, half_carry_cpl, daa_carry_we;
	logic neg_we, neg_set, neg_clr;
	logic carry_we, sec_carry_we, sec_carry_sh, sec_carry_daa, sec_carry_sel;
	logic carry_set, carry_cpl;
	logic carry_in, zero_in, shift_out_in, daa_carry_in, sign_in;
	logic half_carry, daa_carry, neg, carry;

	sm83_op_queue i_sm83_op_queue (.*);

	sm83_alu_control i_sm83_alu_control (.*);

	sm83_alu_core i_sm83_alu_core (
		.core_op        (core_op),
		.a              (head_a),
		.b              (head_b),
		.daa_adjust     (daa_adjust),
		.neg            (neg),
		.carry          (carry),
		.result         (core_result),
		.carry_out      (carry_out),
		.half_carry_out (half_carry_out),
		.zero_out       (zero_out),
		.shift_out      (shift_out)
	);

	// the F byte is registered state and turns over on the same pop edge as result
	sm83_alu_flags i_sm83_alu_flags (
		.dout      (flags),
		.din       (head_b), // POPF brings the flag byte in as b
		.zero      (),
		.pri_carry (),
		.*
	);

	always_ff @(posedge clk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= head_valid; // every head pops, so every head yields a result
	end

	always_ff @(posedge clk) begin
		if (head_valid)
			result <= core_result;
	end

endmodule

// File: verif/tb_sm83_alu_unit.sv
/* SM83 ALU unit testbench
 * runs a hand checked vector table and a random ADD/ADC/SUB/SBC phase through
 * the credit fed queue and checks every result and F byte in issue order
 */
`timescale 1ns/100ps

module tb_sm83_alu_unit;

	localparam int MAX_OPS    = 512; // room for every expectation of the run
	localparam int WAIT_LIMIT = 64;  // cycles any single wait may take
	localparam int RANDOM_OPS = 200;

	logic                               clk;
	logic                               reset;
	logic                               issue_valid;
	sm83_alu_pkg::alu_op_e              issue_op;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] issue_a;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] issue_b;
	logic                               credit_return;
	logic                               result_valid;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] result;
	logic [sm83_alu_pkg::WORD_SIZE-1:0] flags;

	// the driver writes these by issue order and the monitor reads them back in that order
	string                              exp_name   [MAX_OPS];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] exp_result [MAX_OPS];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] exp_flags  [MAX_OPS];

	string                              tab_name [$];
	sm83_alu_pkg::alu_op_e              tab_op   [$];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] tab_a    [$];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] tab_b    [$];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] tab_res  [$];
	logic [sm83_alu_pkg::WORD_SIZE-1:0] tab_flg  [$];

	int          issued         = 0; // credits held are QUEUE_DEPTH - issued + returned
	int          returned       = 0;
	int          checked        = 0;
	int          check_errors   = 0;
	int          timeout_errors = 0;
	logic        stalled        = 1'b0; // set once any wait ran out
	logic [31:0] lcg_state      = 32'd4823;

	sm83_alu_unit i_sm83_alu_unit (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// the adder ops take H and C from the carry or borrow out of bits 3 and 7
	function automatic void model_arith(input sm83_alu_pkg::alu_op_e op, input logic [7:0] a,
	                                    input logic [7:0] b, input logic c,
	                                    output logic [7:0] res, output logic [7:0] fl);
		int   cin;
		int   full;
		int   low;
		logic sub;
		sub = (op == sm83_alu_pkg::OP_SUB) || (op == sm83_alu_pkg::OP_SBC);
		cin = ((op == sm83_alu_pkg::OP_ADC || op == sm83_alu_pkg::OP_SBC) && c) ? 1 : 0;
		if (sub) begin
			full = int'(a) - int'(b) - cin;
			low  = int'(a[3:0]) - int'(b[3:0]) - cin;
		end else begin
			full = int'(a) + int'(b) + cin;
			low  = int'(a[3:0]) + int'(b[3:0]) + cin;
		end
		res                    = 8'(full);
		fl                     = '0; // low nibble of F is always zero
		fl[sm83_alu_pkg::FLAG_Z] = (res == 8'h00);
		fl[sm83_alu_pkg::FLAG_N] = sub;
		fl[sm83_alu_pkg::FLAG_H] = sub ? (low < 0) : (low > 15);
		fl[sm83_alu_pkg::FLAG_C] = sub ? (full < 0) : (full > 255);
	endfunction

	function automatic void add_vector(input string name, input sm83_alu_pkg::alu_op_e op,
	                                   input logic [7:0] a, input logic [7:0] b,
	                                   input logic [7:0] res, input logic [7:0] fl);
		tab_name.push_back(name);
		tab_op.push_back(op);
		tab_a.push_back(a);
		tab_b.push_back(b);
		tab_res.push_back(res);
		tab_flg.push_back(fl);
	endfunction

	// each row expects the flags that the rows above it left behind since reset
	function automatic void load_table();
		add_vector("add_carry",   sm83_alu_pkg::OP_ADD,  8'h3A, 8'hC6, 8'h00, 8'hB0);
		add_vector("adc_half",    sm83_alu_pkg::OP_ADC,  8'h0F, 8'h01, 8'h11, 8'h20);
		add_vector("sub_borrow",  sm83_alu_pkg::OP_SUB,  8'h10, 8'h20, 8'hF0, 8'h50);
		add_vector("sbc_zero",    sm83_alu_pkg::OP_SBC,  8'h10, 8'h0F, 8'h00, 8'hE0);
		add_vector("cp_equal",    sm83_alu_pkg::OP_CP,   8'h42, 8'h42, 8'h42, 8'hC0);
		add_vector("cp_borrow",   sm83_alu_pkg::OP_CP,   8'h01, 8'h02, 8'h01, 8'h70);
		add_vector("and_zero",    sm83_alu_pkg::OP_AND,  8'hF0, 8'h0F, 8'h00, 8'hA0);
		add_vector("xor_mix",     sm83_alu_pkg::OP_XOR,  8'hFF, 8'h0F, 8'hF0, 8'h00);
		add_vector("or_zero",     sm83_alu_pkg::OP_OR,   8'h00, 8'h00, 8'h00, 8'h80);
		add_vector("popf_znh",    sm83_alu_pkg::OP_POPF, 8'h00, 8'hE0, 8'h00, 8'hE0);
		add_vector("scf_keep_z",  sm83_alu_pkg::OP_SCF,  8'h55, 8'h00, 8'h55, 8'h90);
		add_vector("cp_before_rl", sm83_alu_pkg::OP_CP,  8'h01, 8'h02, 8'h01, 8'h70);
		add_vector("rl_through",  sm83_alu_pkg::OP_RL,   8'h80, 8'h00, 8'h01, 8'h10);
		add_vector("cp_before_rr", sm83_alu_pkg::OP_CP,  8'h01, 8'h02, 8'h01, 8'h70);
		add_vector("rr_through",  sm83_alu_pkg::OP_RR,   8'h01, 8'h00, 8'h80, 8'h10);
		add_vector("popf_set_all", sm83_alu_pkg::OP_POPF, 8'h12, 8'hF0, 8'h12, 8'hF0);
		add_vector("ccf_clear",   sm83_alu_pkg::OP_CCF,  8'h12, 8'h00, 8'h12, 8'h80);
		add_vector("add_bcd",     sm83_alu_pkg::OP_ADD,  8'h45, 8'h38, 8'h7D, 8'h00);
		add_vector("daa_add",     sm83_alu_pkg::OP_DAA,  8'h7D, 8'h00, 8'h83, 8'h00);
		add_vector("add_bcd_top", sm83_alu_pkg::OP_ADD,  8'h99, 8'h01, 8'h9A, 8'h00);
		add_vector("daa_overflow", sm83_alu_pkg::OP_DAA, 8'h9A, 8'h00, 8'h00, 8'h90);
		add_vector("sub_bcd",     sm83_alu_pkg::OP_SUB,  8'h42, 8'h15, 8'h2D, 8'h60);
		add_vector("daa_sub",     sm83_alu_pkg::OP_DAA,  8'h2D, 8'h00, 8'h27, 8'h40);
		add_vector("popf_nc",     sm83_alu_pkg::OP_POPF, 8'h33, 8'h5F, 8'h33, 8'h50);
		add_vector("adc_popf_c",  sm83_alu_pkg::OP_ADC,  8'h01, 8'h01, 8'h03, 8'h00);
		add_vector("popf_all",    sm83_alu_pkg::OP_POPF, 8'h0C, 8'hFF, 8'h0C, 8'hF0);
		add_vector("adc_wrap",    sm83_alu_pkg::OP_ADC,  8'hFF, 8'h00, 8'h00, 8'hB0);
	endfunction

	// holds issue_valid for one cycle and only ever spends a credit it owns
	task automatic issue_operation(input sm83_alu_pkg::alu_op_e op, input logic [7:0] a,
	                               input logic [7:0] b, input string name,
	                               input logic [7:0] res, input logic [7:0] fl);
		int waited;
		waited = 0;
		while (issued - returned >= sm83_alu_pkg::QUEUE_DEPTH && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#0.5;
			waited++;
		end
		if (issued - returned >= sm83_alu_pkg::QUEUE_DEPTH) begin
			timeout_errors++;
			stalled = 1'b1;
			$display("timed out waiting for a credit before %s", name);
		end else begin
			exp_name[issued]   = name;
			exp_result[issued] = res;
			exp_flags[issued]  = fl;
			issue_valid        = 1'b1;
			issue_op           = op;
			issue_a            = a;
			issue_b            = b;
			issued++;
			@(posedge clk);
			#0.5;
			issue_valid = 1'b0;
		end
	endtask

	// idle means every credit is back and every result has been checked
	task automatic wait_idle(input string phase);
		int waited;
		waited = 0;
		while ((returned != issued || checked != issued) && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#0.5;
			waited++;
		end
		if (returned != issued || checked != issued) begin
			timeout_errors++;
			stalled = 1'b1;
			$display("timed out waiting for the DUT to go idle after %s", phase);
		end
	endtask

	task automatic run_table();
		for (int i = 0; i < tab_op.size() && !stalled; i++)
			issue_operation(tab_op[i], tab_a[i], tab_b[i], tab_name[i], tab_res[i], tab_flg[i]);
	endtask

	// issues come in bursts of QUEUE_DEPTH and the queue drains between bursts
	task automatic run_random(input logic carry_start);
		logic                  model_c;
		logic [7:0]            a;
		logic [7:0]            b;
		logic [7:0]            res;
		logic [7:0]            fl;
		sm83_alu_pkg::alu_op_e op;
		model_c = carry_start;
		for (int i = 0; i < RANDOM_OPS && !stalled; i++) begin
			lcg_state = lcg_next(lcg_state);
			a         = lcg_state[31:24]; // the upper bits of an LCG have the longest period
			case (lcg_state[21:20])
				2'd0:    op = sm83_alu_pkg::OP_ADD;
				2'd1:    op = sm83_alu_pkg::OP_ADC;
				2'd2:    op = sm83_alu_pkg::OP_SUB;
				default: op = sm83_alu_pkg::OP_SBC;
			endcase
			lcg_state = lcg_next(lcg_state);
			b         = lcg_state[31:24];
			model_arith(op, a, b, model_c, res, fl);
			model_c = fl[sm83_alu_pkg::FLAG_C]; // in order completion keeps the model in step
			issue_operation(op, a, b, $sformatf("random_%0d", i), res, fl);
			if (i % sm83_alu_pkg::QUEUE_DEPTH == sm83_alu_pkg::QUEUE_DEPTH - 1 && !stalled)
				wait_idle("a random burst");
		end
	endtask

	// outputs are stable by the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (credit_return)
				returned++;
			assert (returned <= issued) else begin
				check_errors++;
				$display("credit count rose above %0d", sm83_alu_pkg::QUEUE_DEPTH);
			end
			if (result_valid) begin
				assert (checked < issued) else begin
					check_errors++;
					$display("a result arrived with no operation outstanding");
				end
				if (checked < issued) begin
					assert (result === exp_result[checked]) else begin
						check_errors++;
						$display("[FAIL] %s result expected %02h actual %02h",
						         exp_name[checked], exp_result[checked], result);
					end
					assert (flags === exp_flags[checked]) else begin
						check_errors++;
						$display("[FAIL] %s flags expected %02h actual %02h",
						         exp_name[checked], exp_flags[checked], flags);
					end
					checked++;
				end
			end
		end
	end

	initial begin
		reset       = 1'b1;
		issue_valid = 1'b0;
		issue_op    = sm83_alu_pkg::OP_ADD;
		issue_a     = '0;
		issue_b     = '0;
		load_table();
		repeat (3) @(posedge clk);
		#0.5;
		reset = 1'b0;
		run_table();
		if (!stalled)
			wait_idle("the vector table");
		if (!stalled)
			run_random(tab_flg[tab_flg.size() - 1][sm83_alu_pkg::FLAG_C]);
		if (!stalled)
			wait_idle("the random phase");
		$display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: sm83_alu_unit.f
hw/sm83_alu_pkg.sv
hw/sm83_op_queue.sv
hw/sm83_alu_control.sv
hw/sm83_alu_core.sv
hw/sm83_alu_flags.sv
hw/sm83_alu_unit.sv
verif/tb_sm83_alu_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the ALU unit testbench with Verilator, runs it and checks the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sm83_alu_unit \
	-f sm83_alu_unit.f -o tb_sm83_alu_unit

sim_out=$(./obj_dir/tb_sm83_alu_unit)
printf '%s\n' "$sim_out"

if grep -qx "TESTBENCH PASSED" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
